/* fftPkg.sv */
package fftPkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes

  localparam int FFT_POINTS   = 32;                        // points per frame
  localparam int LOG2_POINTS  = 5;                         // radix-2 stages
  localparam int ADDR_W       = 5;                         // store address
  localparam int SAMPLE_W     = 16;                        // input sample, signed
  localparam int DATA_W       = 18;                        // working value, signed
  localparam int TWIDDLE_W    = 16;                        // twiddle part, signed
  localparam int TWIDDLE_FRAC = 14;                        // 1.0 == 2**14
  localparam int MAG_W        = 20;                        // magnitude, unsigned
  localparam int STAGE_W      = $clog2(LOG2_POINTS + 1);   // stage count incl. done
  localparam int PEND_W       = 3;                         // 0..4 butterflies in flight

  ////////////////////////////////////////////////////////////////////////////
  // types

  typedef logic signed [SAMPLE_W-1:0] sampleT;
  typedef logic [MAG_W-1:0] magT;

  typedef struct packed {
    logic signed [DATA_W-1:0] re;
    logic signed [DATA_W-1:0] im;
  } complexT;                                               // 36 bits

  typedef struct packed {
    logic signed [TWIDDLE_W-1:0] cosVal;
    logic signed [TWIDDLE_W-1:0] sinVal;
  } twiddleT;                                               // 32 bits

  typedef struct packed {
    logic [ADDR_W-1:0] addrTop;                             // gets (a+b)/2
    logic [ADDR_W-1:0] addrBot;                             // gets (a-b)/2 * conj(w)
  } bflyTagT;                                               // 10 bits

  typedef enum logic [2:0] {
    stLoad,                                                 // idle, accepting samples
    stStage,                                                // stage start
    stIssue,                                                // one butterfly per cycle
    stDrain,                                                // wait for write-backs
    stMag,                                                  // magnitude pass
    stReadout                                               // bit-reversed readout
  } ctrlStateT;

  ////////////////////////////////////////////////////////////////////////////
  // twiddles, cos/sin(2*pi*k/FFT_POINTS) * 2**TWIDDLE_FRAC

  // quarter wave, values rounded to nearest (no exact halves at this size)
  function automatic logic signed [TWIDDLE_W-1:0] quarterCos(input int q);
    case (q)
      0: return 16384;
      1: return 16069;
      2: return 15137;
      3: return 13623;
      4: return 11585;
      5: return 9102;
      6: return 6270;
      7: return 3196;
      default: return 0;
    endcase
  endfunction

  function automatic logic signed [TWIDDLE_W-1:0] twiddleCos(input int k);
    int kk;
    kk = k & (FFT_POINTS - 1);                              // wrap, negative k too
    if (kk <= FFT_POINTS / 4) return quarterCos(kk);
    else if (kk <= FFT_POINTS / 2) return -quarterCos(FFT_POINTS / 2 - kk);
    else if (kk <= 3 * FFT_POINTS / 4) return -quarterCos(kk - FFT_POINTS / 2);
    else return quarterCos(FFT_POINTS - kk);
  endfunction

  // sin(x) = cos(x - pi/2)
  function automatic logic signed [TWIDDLE_W-1:0] twiddleSin(input int k);
    return twiddleCos(k - FFT_POINTS / 4);
  endfunction

endpackage

/* sampleBuffer.sv */
`timescale 1ns/1ps

// dual read / dual write complex store, registered reads
module sampleBuffer import fftPkg::*; (
  input  logic              clk,
  input  logic [ADDR_W-1:0] rdAddrA,
  input  logic [ADDR_W-1:0] rdAddrB,
  output complexT           rdDataA,
  output complexT           rdDataB,
  input  logic              wrEnA,
  input  logic [ADDR_W-1:0] wrAddrA,
  input  complexT           wrDataA,
  input  logic              wrEnB,
  input  logic [ADDR_W-1:0] wrAddrB,
  input  complexT           wrDataB
);

  complexT mem [FFT_POINTS];                                // working store

  // both butterfly results land in the same cycle
  always_ff @(posedge clk) begin
    if (wrEnA) begin
      mem[wrAddrA] <= wrDataA;                              // load sample or top result
    end
    if (wrEnB) begin
      mem[wrAddrB] <= wrDataB;                              // bottom result
    end
  end

  // read-before-write, controller drains between stages
  always_ff @(posedge clk) begin
    rdDataA <= mem[rdAddrA];                                // one cycle latency
    rdDataB <= mem[rdAddrB];
  end

endmodule

/* twiddleRom.sv */
`timescale 1ns/1ps

// half-period twiddle table with one cycle of read latency
module twiddleRom import fftPkg::*; (
  input  logic                clk,
  input  logic [ADDR_W-2:0]   addr,
  output twiddleT             twiddle
);

  twiddleT twTable [FFT_POINTS/2];                          // k = 0 .. N/2-1

  // constant contents from the package functions
  for (genvar k = 0; k < FFT_POINTS / 2; k++) begin : gTable
    assign twTable[k] = '{cosVal: twiddleCos(k), sinVal: twiddleSin(k)};
  end

  always_ff @(posedge clk) begin
    twiddle <= twTable[addr];                               // aligned with store reads
  end

endmodule

/* butterfly.sv */
`timescale 1ns/1ps

// radix-2 DIF butterfly, two pipeline stages
//   top    = (a + b) / 2
//   bottom = ((a - b) / 2) * (cos - j sin)
module butterfly import fftPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    inValid,
  input  complexT a,
  input  complexT b,
  input  twiddleT w,
  input  bflyTagT inTag,
  output logic    outValid,
  output complexT top,
  output complexT bottom,
  output bflyTagT outTag
);

  logic signed [DATA_W:0] sumRe;                            // one guard bit
  logic signed [DATA_W:0] sumIm;
  logic signed [DATA_W:0] difRe;
  logic signed [DATA_W:0] difIm;

  logic    s1Valid;
  complexT s1Sum;                                           // already halved
  complexT s1Dif;                                           // already halved
  twiddleT s1W;
  bflyTagT s1Tag;

  logic signed [DATA_W+TWIDDLE_W-1:0] prodRc;               // re * cos
  logic signed [DATA_W+TWIDDLE_W-1:0] prodIs;               // im * sin
  logic signed [DATA_W+TWIDDLE_W-1:0] prodIc;               // im * cos
  logic signed [DATA_W+TWIDDLE_W-1:0] prodRs;               // re * sin
  logic signed [DATA_W+TWIDDLE_W:0]   accRe;
  logic signed [DATA_W+TWIDDLE_W:0]   accIm;

  assign sumRe = a.re + b.re;
  assign sumIm = a.im + b.im;
  assign difRe = a.re - b.re;
  assign difIm = a.im - b.im;

  // conjugate twiddle product
  assign prodRc = s1Dif.re * s1W.cosVal;
  assign prodIs = s1Dif.im * s1W.sinVal;
  assign prodIc = s1Dif.im * s1W.cosVal;
  assign prodRs = s1Dif.re * s1W.sinVal;
  assign accRe  = prodRc + prodIs;
  assign accIm  = prodIc - prodRs;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid  <= 1'b0;
      outValid <= 1'b0;
    end else begin
      s1Valid  <= inValid;
      outValid <= s1Valid;
    end
  end

  always_ff @(posedge clk) begin
    // cycle 1, sum/diff then arithmetic >>1 (stage scaling)
    s1Sum.re <= sumRe[DATA_W:1];
    s1Sum.im <= sumIm[DATA_W:1];
    s1Dif.re <= difRe[DATA_W:1];
    s1Dif.im <= difIm[DATA_W:1];
    s1W      <= w;
    s1Tag    <= inTag;
    // cycle 2, drop TWIDDLE_FRAC bits = floor
    top       <= s1Sum;
    bottom.re <= accRe[TWIDDLE_FRAC +: DATA_W];
    bottom.im <= accIm[TWIDDLE_FRAC +: DATA_W];
    outTag    <= s1Tag;
  end

endmodule

/* magnitudeUnit.sv */
`timescale 1ns/1ps

// |z| ~ max(|re|,|im|) + min(|re|,|im|)/4, two cycles
module magnitudeUnit import fftPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    inValid,
  input  complexT bin,
  output logic    outValid,
  output magT     mag
);

  logic              s1Valid;
  logic [DATA_W-1:0] absRe;                                 // unsigned, -2**17 fits
  logic [DATA_W-1:0] absIm;
  logic [DATA_W-1:0] larger;
  logic [DATA_W-1:0] smaller;

  assign larger  = (absRe >= absIm) ? absRe : absIm;
  assign smaller = (absRe >= absIm) ? absIm : absRe;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1Valid  <= 1'b0;
      outValid <= 1'b0;
    end else begin
      s1Valid  <= inValid;
      outValid <= s1Valid;
    end
  end

  always_ff @(posedge clk) begin
    absRe <= bin.re[DATA_W-1] ? -bin.re : bin.re;           // cycle 1
    absIm <= bin.im[DATA_W-1] ? -bin.im : bin.im;
    mag   <= MAG_W'(larger) + MAG_W'(smaller >> 2);         // cycle 2
  end

endmodule

/* fftController.sv */
`timescale 1ns/1ps

module fftController import fftPkg::*; (
  input  logic              clk,
  input  logic              rst,
  // sample stream in
  input  sampleT            sampleIn,
  input  logic              sampleValid,
  output logic              sampleReady,
  // magnitude stream out
  output magT               magOut,
  output logic              magValid,
  input  logic              magReady,
  // working store
  output logic [ADDR_W-1:0] rdAddrA,
  output logic [ADDR_W-1:0] rdAddrB,
  output logic              wrEnA,
  output logic [ADDR_W-1:0] wrAddrA,
  output complexT           wrDataA,
  output logic              wrEnB,
  output logic [ADDR_W-1:0] wrAddrB,
  output complexT           wrDataB,
  // butterfly
  output logic [ADDR_W-2:0] twAddr,
  output logic              bflyValid,
  output bflyTagT           bflyTag,
  input  logic              bflyDoneValid,
  input  bflyTagT           bflyDoneTag,
  input  complexT           bflyTop,
  input  complexT           bflyBottom,
  // magnitude unit
  output logic              magInValid,
  input  logic              magResValid,
  input  magT               magRes
);

  ctrlStateT          state;
  logic [ADDR_W:0]    idx;                                  // load / bfly / mag / readout
  logic [STAGE_W-1:0] stage;
  logic [PEND_W-1:0]  pending;                              // issued, not yet written
  logic [ADDR_W-1:0]  magWrIdx;
  logic               loadWrEn;
  logic [ADDR_W-1:0]  loadAddr;
  complexT            loadData;
  magT                magBuf [FFT_POINTS];                  // bit-reversed bin order

  logic [ADDR_W-1:0]  span;
  logic [ADDR_W-1:0]  pos;
  logic [ADDR_W-1:0]  lower;
  logic [ADDR_W-1:0]  upper;
  logic               issue;
  logic               accept;
  logic               outAdvance;

  function automatic logic [ADDR_W-1:0] bitReverse(input logic [ADDR_W-1:0] v);
    logic [ADDR_W-1:0] r;
    for (int i = 0; i < ADDR_W; i++) begin
      r[i] = v[ADDR_W-1-i];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // butterfly addressing

  assign span   = ADDR_W'(FFT_POINTS >> (stage + 1));       // 16, 8, 4, 2, 1
  assign pos    = idx[ADDR_W-1:0] & (span - 1'b1);          // position in group
  assign lower  = ((idx[ADDR_W-1:0] & ~(span - 1'b1)) << 1) | pos;
  assign upper  = lower + span;
  assign twAddr = (ADDR_W-1)'(pos << stage);                // stride doubles per stage

  assign issue       = (state == stIssue);
  assign sampleReady = (state == stLoad);
  assign accept      = sampleValid && sampleReady;
  assign outAdvance  = (state == stReadout) && (!magValid || magReady);

  assign rdAddrA = (state == stMag) ? idx[ADDR_W-1:0] : lower;
  assign rdAddrB = upper;

  // port A shared by load and top result, never in the same cycle
  assign wrEnA   = loadWrEn | bflyDoneValid;
  assign wrAddrA = loadWrEn ? loadAddr : bflyDoneTag.addrTop;
  assign wrDataA = loadWrEn ? loadData : bflyTop;
  assign wrEnB   = bflyDoneValid;
  assign wrAddrB = bflyDoneTag.addrBot;
  assign wrDataB = bflyBottom;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= stLoad;
      idx        <= '0;
      stage      <= '0;
      pending    <= '0;
      magWrIdx   <= '0;
      loadWrEn   <= 1'b0;
      bflyValid  <= 1'b0;
      magInValid <= 1'b0;
      magValid   <= 1'b0;
    end else begin
      loadWrEn   <= accept;
      bflyValid  <= issue;                                  // store read lands next cycle
      magInValid <= (state == stMag) && !idx[ADDR_W];
      pending    <= pending + PEND_W'(issue) - PEND_W'(bflyDoneValid);
      if (magResValid) begin
        magWrIdx <= magWrIdx + 1'b1;                        // wraps to 0 after last bin
      end
      case (state)
        stLoad: begin
          if (accept) begin
            idx <= idx + 1'b1;
            if (idx[ADDR_W-1:0] == ADDR_W'(FFT_POINTS - 1)) begin
              idx   <= '0;
              stage <= '0;
              state <= stStage;
            end
          end
        end
        stStage: begin
          state <= (stage == STAGE_W'(LOG2_POINTS)) ? stMag : stIssue;
        end
        stIssue: begin
          idx <= idx + 1'b1;
          if (idx[ADDR_W-2:0] == '1) begin                  // N/2 butterflies issued
            idx   <= '0;
            state <= stDrain;
          end
        end
        stDrain: begin
          if (pending == '0) begin                          // all results written back
            stage <= stage + 1'b1;
            state <= stStage;
          end
        end
        stMag: begin
          if (!idx[ADDR_W]) begin
            idx <= idx + 1'b1;                              // store read in address order
          end
          if (magResValid && magWrIdx == ADDR_W'(FFT_POINTS - 1)) begin
            idx   <= '0;
            state <= stReadout;
          end
        end
        stReadout: begin
          if (outAdvance) begin
            if (!idx[ADDR_W]) begin
              magValid <= 1'b1;
              idx      <= idx + 1'b1;
            end else begin
              magValid <= 1'b0;                             // last bin taken
              idx      <= '0;
              state    <= stLoad;
            end
          end
        end
        default: state <= stLoad;
      endcase
    end
  end

  // payload registers and magnitude buffer
  always_ff @(posedge clk) begin
    if (accept) begin
      loadAddr <= idx[ADDR_W-1:0];                          // natural sample order
      loadData <= '{re: {{(DATA_W-SAMPLE_W){sampleIn[SAMPLE_W-1]}}, sampleIn}, im: '0};
    end
    bflyTag <= '{addrTop: lower, addrBot: upper};
    if (magResValid) begin
      magBuf[magWrIdx] <= magRes;
    end
    if (outAdvance && !idx[ADDR_W]) begin
      magOut <= magBuf[bitReverse(idx[ADDR_W-1:0])];       // natural bin order out
    end
  end

endmodule

/* spectrumAnalyzer.sv */
`timescale 1ns/1ps

module spectrumAnalyzer import fftPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  sampleT sampleIn,
  input  logic   sampleValid,
  output logic   sampleReady,
  output magT    magOut,
  output logic   magValid,
  input  logic   magReady
);

  ////////////////////////////////////////////////////////////////////////////
  // internal nets

  logic [ADDR_W-1:0] rdAddrA;
  logic [ADDR_W-1:0] rdAddrB;
  complexT           rdDataA;                               // bfly a, magnitude bin
  complexT           rdDataB;                               // bfly b
  logic              wrEnA;
  logic [ADDR_W-1:0] wrAddrA;
  complexT           wrDataA;
  logic              wrEnB;
  logic [ADDR_W-1:0] wrAddrB;
  complexT           wrDataB;
  logic [ADDR_W-2:0] twAddr;
  twiddleT           twiddle;
  logic              bflyValid;
  bflyTagT           bflyTag;
  logic              bflyDoneValid;
  bflyTagT           bflyDoneTag;
  complexT           bflyTop;
  complexT           bflyBottom;
  logic              magInValid;
  logic              magResValid;
  magT               magRes;

  ////////////////////////////////////////////////////////////////////////////
  // blocks

  fftController ctrl (
    .clk, .rst,
    .sampleIn, .sampleValid, .sampleReady,
    .magOut, .magValid, .magReady,
    .rdAddrA, .rdAddrB,
    .wrEnA, .wrAddrA, .wrDataA,
    .wrEnB, .wrAddrB, .wrDataB,
    .twAddr, .bflyValid, .bflyTag,
    .bflyDoneValid, .bflyDoneTag, .bflyTop, .bflyBottom,
    .magInValid, .magResValid, .magRes
  );

  sampleBuffer store (
    .clk,
    .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
    .wrEnA, .wrAddrA, .wrDataA,
    .wrEnB, .wrAddrB, .wrDataB
  );

  twiddleRom twRom (.clk, .addr(twAddr), .twiddle);

  butterfly bfly (
    .clk, .rst,
    .inValid(bflyValid), .a(rdDataA), .b(rdDataB), .w(twiddle), .inTag(bflyTag),
    .outValid(bflyDoneValid), .top(bflyTop), .bottom(bflyBottom), .outTag(bflyDoneTag)
  );

  magnitudeUnit magUnit (
    .clk, .rst,
    .inValid(magInValid), .bin(rdDataA),
    .outValid(magResValid), .mag(magRes)
  );

endmodule

/* clockGen.sv */
`timescale 1ns/1ps

// free-running testbench clock and power-on reset
module clockGen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;                    // 50% duty
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);                   // high over RESET_CYCLES edges
    @(negedge clk);
    rst = 1'b0;                                             // released on a falling edge
  end

endmodule

/* spectrumAnalyzerTb.sv */
`timescale 1ns/1ps

module spectrumAnalyzerTb import fftPkg::*; ();

  localparam int CLK_PERIOD   = 40;                         // ns
  localparam int SEED         = 23;
  localparam int NUM_TESTS    = 9;                          // reset check + 8 frames
  localparam int FRAME_CYCLES = 260;                        // load, 5 stages, mag pass, slow readout
  localparam int PATTERN_LEN  = 64;                         // magReady toggle pattern

  logic   clk;
  logic   rst;
  sampleT sampleIn;
  logic   sampleValid;
  logic   sampleReady;
  magT    magOut;
  logic   magValid;
  logic   magReady;

  int    frame [FFT_POINTS];                                // current input frame
  magT   expQ [$];                                          // expected bins, all frames in flight
  string nameQ [$];                                         // one name per frame in flight
  logic  readyPattern [PATTERN_LEN];
  logic  pressureOn;
  int    framesQueued;
  int    framesDone;
  int    samplesAccepted;
  int    binCount;
  int    frameErrors;
  int    errorCount;
  int    testsRun;
  int    testsFailed;
  int    cycleCount = 0;
  logic  lastValid;
  logic  lastReady;
  magT   lastMag;

  clockGen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) clkSrc (.clk, .rst);

  spectrumAnalyzer DUT (
    .clk, .rst,
    .sampleIn, .sampleValid, .sampleReady,
    .magOut, .magValid, .magReady
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic longint wrapData(input longint v);
    logic signed [DATA_W-1:0] t;
    t = DATA_W'(v);                                         // keep DATA_W bits
    return t;                                               // sign extended back
  endfunction

  function automatic int reverseBits(input int v);
    int r;
    r = 0;
    for (int i = 0; i < LOG2_POINTS; i++) begin
      r = (r << 1) | ((v >> i) & 1);
    end
    return r;
  endfunction

  // fixed-point DIF FFT of frame[], magnitudes pushed in natural bin order
  function automatic void modelSpectrum();
    longint re [FFT_POINTS];
    longint im [FFT_POINTS];
    longint ar, ai, br, bi, dr, di, c, s, hi, lo;
    int     span;
    for (int n = 0; n < FFT_POINTS; n++) begin
      re[n] = frame[n];                                     // real input, im zero
      im[n] = 0;
    end
    for (int st = 0; st < LOG2_POINTS; st++) begin
      span = FFT_POINTS >> (st + 1);
      for (int base = 0; base < FFT_POINTS; base += 2 * span) begin
        for (int p = 0; p < span; p++) begin
          ar = re[base + p];
          ai = im[base + p];
          br = re[base + p + span];
          bi = im[base + p + span];
          c  = twiddleCos(p << st);
          s  = twiddleSin(p << st);
          dr = (ar - br) >>> 1;                             // halved per stage, floor
          di = (ai - bi) >>> 1;
          re[base + p] = (ar + br) >>> 1;
          im[base + p] = (ai + bi) >>> 1;
          re[base + p + span] = wrapData((dr * c + di * s) >>> TWIDDLE_FRAC);
          im[base + p + span] = wrapData((di * c - dr * s) >>> TWIDDLE_FRAC);
        end
      end
    end
    for (int k = 0; k < FFT_POINTS; k++) begin
      ar = re[reverseBits(k)];                              // store is bit-reversed
      ai = im[reverseBits(k)];
      ar = (ar < 0) ? -ar : ar;
      ai = (ai < 0) ? -ai : ai;
      hi = (ar >= ai) ? ar : ai;
      lo = (ar >= ai) ? ai : ar;
      expQ.push_back(magT'(hi + (lo >> 2)));                // larger + smaller/4
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers

  task automatic reportTest(input string name, input int errs);
    testsRun++;
    if (errs != 0) testsFailed++;
    $display("test %-14s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  task automatic fillRandom();
    for (int n = 0; n < FFT_POINTS; n++) begin
      frame[n] = int'(sampleT'($urandom()));                // full 16-bit range
    end
  endtask

  // called on a falling edge, returns on one
  task automatic sendFrame(input string name);
    int   n;
    logic took;
    modelSpectrum();
    nameQ.push_back(name);
    framesQueued++;
    n = 0;
    while (n < FFT_POINTS) begin
      sampleIn    = sampleT'(frame[n]);
      sampleValid = 1'b1;
      took        = sampleReady;                            // only moves on the rising edge
      @(negedge clk);
      if (took) n++;
    end
    sampleValid = 1'b0;
  endtask

  task automatic waitFramesDone();
    wait (framesDone == framesQueued);                      // watchdog bounds this
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output side

  always @(negedge clk) begin
    cycleCount++;
    magReady = pressureOn ? readyPattern[cycleCount % PATTERN_LEN] : 1'b1;
  end

  always @(posedge clk) begin : compare
    magT expVal;
    if (!rst) begin
      if (lastValid && !lastReady && (!magValid || magOut !== lastMag)) begin
        $display("ERROR magnitude output changed while stalled by magReady");
        frameErrors++;
        errorCount++;
      end
      if (sampleReady && (samplesAccepted / FFT_POINTS) > framesDone) begin
        $display("ERROR sampleReady high before the last bin of a frame was taken");
        frameErrors++;
        errorCount++;
      end
      if (sampleValid && sampleReady) samplesAccepted++;
      if (magValid && magReady) begin
        if (expQ.size() == 0) begin
          $display("ERROR magnitude accepted with no frame pending");
          errorCount++;
        end else begin
          expVal = expQ.pop_front();
          if (magOut !== expVal) begin
            $display("CHECK FAILED %s bin %0d expected %0d actual %0d",
                     nameQ[0], binCount, expVal, magOut);
            frameErrors++;
            errorCount++;
          end
          binCount++;
          if (binCount == FFT_POINTS) begin                 // frame complete
            reportTest(nameQ.pop_front(), frameErrors);
            binCount    = 0;
            frameErrors = 0;
            framesDone++;
          end
        end
      end
    end
    lastValid = magValid;
    lastReady = magReady;
    lastMag   = magOut;
  end

  initial begin : watchdog
    #(NUM_TESTS * FRAME_CYCLES * CLK_PERIOD * 3);
    $display("timeout: run did not finish within the expected %0d frame lengths", NUM_TESTS);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin : stimulus
    int errs;
    void'($urandom(SEED));
    sampleIn    = '0;
    sampleValid = 1'b0;
    magReady    = 1'b1;
    pressureOn  = 1'b0;
    errorCount  = 0;
    for (int i = 0; i < PATTERN_LEN; i++) begin
      readyPattern[i] = ($urandom() % 2) != 0;
    end
    @(posedge clk);
    while (rst) @(posedge clk);
    @(negedge clk);

    errs = 0;                                               // state right after reset
    if (sampleReady !== 1'b1) begin
      $display("CHECK FAILED afterReset sampleReady expected 1 actual %b", sampleReady);
      errs++;
    end
    if (magValid !== 1'b0) begin
      $display("CHECK FAILED afterReset magValid expected 0 actual %b", magValid);
      errs++;
    end
    errorCount += errs;
    reportTest("afterReset", errs);

    for (int n = 0; n < FFT_POINTS; n++) frame[n] = 0;
    frame[0] = 16384;                                       // impulse, flat spectrum
    sendFrame("impulse");
    for (int n = 0; n < FFT_POINTS; n++) frame[n] = twiddleCos(3 * n);
    sendFrame("cosineBin3");                                // peaks at bins 3 and 29
    for (int t = 0; t < 3; t++) begin
      fillRandom();
      sendFrame($sformatf("random%0d", t));
    end
    waitFramesDone();

    pressureOn = 1'b1;                                      // random magReady
    fillRandom();
    sendFrame("backPressure");
    waitFramesDone();
    pressureOn = 1'b0;

    fillRandom();
    sendFrame("backToBack0");
    fillRandom();
    sendFrame("backToBack1");                               // waits on sampleReady only
    waitFramesDone();
    repeat (4) @(negedge clk);

    $display("summary: %0d tests, %0d failed, %0d check errors",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0 && testsRun == NUM_TESTS) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* spectrumAnalyzer.f */
fftPkg.sv
sampleBuffer.sv
twiddleRom.sv
butterfly.sv
magnitudeUnit.sv
fftController.sv
spectrumAnalyzer.sv
clockGen.sv
spectrumAnalyzerTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the spectrum analyzer testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module spectrumAnalyzerTb \
  -f spectrumAnalyzer.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

# the testbench prints the fail message on any failed check or timeout
if grep -q "=== FAIL ===" sim.log; then
  echo "result: failed"
  exit 1
fi

echo "result: passed"
exit 0
